// ==== verilog/yaw_settings.svh ====
`ifndef YAW_SETTINGS_SVH
`define YAW_SETTINGS_SVH

// Word widths
`define ANGLE_W 16
`define STICK_W 8

// Extra fraction bits carried by the tracking angle
`define SCALE_BITS 2

// Angles in IMU counts, 16 counts per degree
`define ANGLE_360 5760
`define ANGLE_270 4320
`define ANGLE_90 1440

// Throttle below this value counts as idle
`define THROTTLE_IDLE 10

// Normalized stick strictly inside +/- this value is neutral
`define STICK_DEADBAND 4

// Largest change of the error from one run to the next, about 3 degrees
`define ERROR_MAX_CHANGE 50

`endif

// ==== verilog/yaw_angle_pkg.sv ====
`default_nettype none

`include "yaw_settings.svh"

package yaw_angle_pkg;

	// IMU angle word, 12 integer and 4 fraction bits, two's complement
	// Also used for every intermediate angle and error in the datapath
	typedef logic signed [`ANGLE_W-1:0] angle_t;

	// Raw receiver value for throttle and yaw stick
	typedef logic [`STICK_W-1:0] stick_t;

endpackage

`default_nettype wire

// ==== verilog/yaw_seq_pkg.sv ====
`default_nettype none

package yaw_seq_pkg;

	// One state per step of a run, walked in this order
	typedef enum logic [3:0] {
		IDLE,
		LATCH,
		NEUTRAL,
		NORMALIZE,
		WINDOW,
		TRACK_SUM,
		TRACK_WRAP,
		TARGET,
		ERR_DIFF,
		ERR_WRAP,
		ERR_RATE,
		ERR_CLAMP,
		COMPLETE
	} yaw_step_t;

endpackage

`default_nettype wire

// ==== verilog/yaw_sequencer.sv ====
`default_nettype none

module yaw_sequencer (
	input  wire  us_clk,
	input  wire  resetn,
	input  wire  start_signal,
	output logic active_signal,
	output logic complete_signal,
	output wire  latch_step,
	output wire  neutral_step,
	output wire  normalize_step,
	output wire  window_step,
	output wire  track_sum_step,
	output wire  track_wrap_step,
	output wire  target_step,
	output wire  err_diff_step,
	output wire  err_wrap_step,
	output wire  err_rate_step,
	output wire  err_clamp_step,
	output wire  commit_step
);
	import yaw_seq_pkg::*;

	yaw_step_t state;
	yaw_step_t next_state;
	logic      start_pending;

	// A start seen during a run is kept until the sequence is back in IDLE
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			start_pending <= 1'b0;
		end else begin
			start_pending <= start_signal || (start_pending && (state != IDLE));
		end
	end

	always_comb begin
		case (state)
			IDLE:       next_state = start_pending ? LATCH : IDLE;
			LATCH:      next_state = NEUTRAL;
			NEUTRAL:    next_state = NORMALIZE;
			NORMALIZE:  next_state = WINDOW;
			WINDOW:     next_state = TRACK_SUM;
			TRACK_SUM:  next_state = TRACK_WRAP;
			TRACK_WRAP: next_state = TARGET;
			TARGET:     next_state = ERR_DIFF;
			ERR_DIFF:   next_state = ERR_WRAP;
			ERR_WRAP:   next_state = ERR_RATE;
			ERR_RATE:   next_state = ERR_CLAMP;
			ERR_CLAMP:  next_state = COMPLETE;
			COMPLETE:   next_state = IDLE;
			default:    next_state = IDLE;
		endcase
	end

	// Status flags lag the state by one clock
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state           <= IDLE;
			active_signal   <= 1'b0;
			complete_signal <= 1'b0;
		end else begin
			state           <= next_state;
			active_signal   <= (state != IDLE) && (state != COMPLETE);
			complete_signal <= (state == COMPLETE);
		end
	end

	// One strobe per step, each lasts a single cycle
	assign latch_step      = (state == LATCH);
	assign neutral_step    = (state == NEUTRAL);
	assign normalize_step  = (state == NORMALIZE);
	assign window_step     = (state == WINDOW);
	assign track_sum_step  = (state == TRACK_SUM);
	assign track_wrap_step = (state == TRACK_WRAP);
	assign target_step     = (state == TARGET);
	assign err_diff_step   = (state == ERR_DIFF);
	assign err_wrap_step   = (state == ERR_WRAP);
	assign err_rate_step   = (state == ERR_RATE);
	assign err_clamp_step  = (state == ERR_CLAMP);
	assign commit_step     = (state == COMPLETE);

endmodule

`default_nettype wire

// ==== verilog/stick_conditioner.sv ====
`default_nettype none

`include "yaw_settings.svh"

module stick_conditioner (
	input  wire                         us_clk,
	input  wire                         resetn,
	input  wire                         latch_step,
	input  wire                         neutral_step,
	input  wire                         normalize_step,
	input  wire                         window_step,
	input  wire yaw_angle_pkg::stick_t  throttle_pwm_value_input,
	input  wire yaw_angle_pkg::stick_t  yaw_pwm_value_input,
	input  wire yaw_angle_pkg::angle_t  yaw_angle_imu,
	output yaw_angle_pkg::angle_t       imu_angle,
	output yaw_angle_pkg::angle_t       stick_raw,
	output yaw_angle_pkg::angle_t       stick_norm,
	output logic                        throttle_idle,
	output logic                        out_of_window
);
	import yaw_angle_pkg::*;

	localparam int PAD_W = `ANGLE_W - `STICK_W;

	stick_t throttle_lat;
	stick_t yaw_lat;
	stick_t yaw_neutral;
	angle_t neutral_ext;

	// Snapshot of the inputs for the whole run
	always_ff @(posedge us_clk) begin
		if (latch_step) begin
			throttle_lat <= throttle_pwm_value_input;
			yaw_lat      <= yaw_pwm_value_input;
			imu_angle    <= yaw_angle_imu;
		end
	end

	assign throttle_idle = (throttle_lat < `THROTTLE_IDLE);

	// Receiver values widened to the angle word
	assign stick_raw   = {{PAD_W{1'b0}}, yaw_lat};
	assign neutral_ext = {{PAD_W{1'b0}}, yaw_neutral};

	// Neutral is only learned while the motors are idle
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			yaw_neutral <= '0;
		end else if (neutral_step && throttle_idle) begin
			yaw_neutral <= yaw_lat;
		end
	end

	always_ff @(posedge us_clk) begin
		if (normalize_step) begin
			stick_norm <= stick_raw - neutral_ext;
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			out_of_window <= 1'b0;
		end else if (window_step) begin
			out_of_window <= !throttle_idle &&
				!((stick_norm < `STICK_DEADBAND) && (stick_norm > -`STICK_DEADBAND));
		end
	end

endmodule

`default_nettype wire

// ==== verilog/heading_tracker.sv ====
`default_nettype none

`include "yaw_settings.svh"

module heading_tracker (
	input  wire                         us_clk,
	input  wire                         resetn,
	input  wire                         track_sum_step,
	input  wire                         track_wrap_step,
	input  wire                         target_step,
	input  wire                         throttle_idle,
	input  wire                         out_of_window,
	input  wire yaw_angle_pkg::angle_t  stick_norm,
	input  wire yaw_angle_pkg::angle_t  imu_angle,
	output yaw_angle_pkg::angle_t       target_angle
);
	import yaw_angle_pkg::*;

	// Full turn in tracking units, 4 tracking counts per IMU count
	localparam angle_t FULL_TURN = angle_t'(`ANGLE_360 << `SCALE_BITS);

	angle_t track_sum;
	angle_t track_angle;

	always_ff @(posedge us_clk) begin
		if (track_sum_step) begin
			track_sum <= track_angle + stick_norm;
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			track_angle <= '0;
		end else if (track_wrap_step) begin
			if (throttle_idle) begin
				// Follow the IMU so the heading is right at takeoff
				track_angle <= imu_angle <<< `SCALE_BITS;
			end else if (!out_of_window) begin
				track_angle <= track_angle;
			end else if (track_sum > FULL_TURN) begin
				track_angle <= track_sum - FULL_TURN;
			end else if (track_sum < 0) begin
				track_angle <= track_sum + FULL_TURN;
			end else begin
				track_angle <= track_sum;
			end
		end
	end

	// Drop the extra fraction bits to get back to IMU units
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			target_angle <= '0;
		end else if (target_step) begin
			if (throttle_idle) begin
				target_angle <= imu_angle;
			end else begin
				target_angle <= track_angle >>> `SCALE_BITS;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/heading_error.sv ====
`default_nettype none

`include "yaw_settings.svh"

module heading_error (
	input  wire                         us_clk,
	input  wire                         resetn,
	input  wire                         err_diff_step,
	input  wire                         err_wrap_step,
	input  wire                         err_rate_step,
	input  wire                         err_clamp_step,
	input  wire                         commit_step,
	input  wire                         yaac_enable_n,
	input  wire                         throttle_idle,
	input  wire yaw_angle_pkg::angle_t  target_angle,
	input  wire yaw_angle_pkg::angle_t  imu_angle,
	input  wire yaw_angle_pkg::angle_t  stick_raw,
	output yaw_angle_pkg::angle_t       body_yaw_angle_target,
	output yaw_angle_pkg::angle_t       yaw_angle_error_out
);
	import yaw_angle_pkg::*;

	localparam angle_t DEG_90   = angle_t'(`ANGLE_90);
	localparam angle_t DEG_270  = angle_t'(`ANGLE_270);
	localparam angle_t DEG_360  = angle_t'(`ANGLE_360);
	localparam angle_t MAX_STEP = angle_t'(`ERROR_MAX_CHANGE);

	angle_t err_diff;
	angle_t err_wrapped;
	angle_t err_limited;
	angle_t prev_error;
	angle_t rate_floor;
	angle_t rate_ceil;

	always_ff @(posedge us_clk) begin
		if (err_diff_step) begin
			err_diff <= target_angle - imu_angle;
		end
	end

	// Take the short way round when target and IMU sit on opposite sides of north
	always_ff @(posedge us_clk) begin
		if (err_wrap_step) begin
			if (throttle_idle) begin
				err_wrapped <= '0;
			end else if ((target_angle > DEG_270) && (imu_angle < DEG_90)) begin
				err_wrapped <= -(DEG_360 - target_angle + imu_angle);
			end else if ((imu_angle > DEG_270) && (target_angle < DEG_90)) begin
				err_wrapped <= DEG_360 - imu_angle + target_angle;
			end else begin
				err_wrapped <= err_diff;
			end
		end
	end

	assign rate_floor = prev_error - MAX_STEP;
	assign rate_ceil  = prev_error + MAX_STEP;

	// A full flip of sign across the limits is held at the old side
	always_ff @(posedge us_clk) begin
		if (err_rate_step) begin
			if ((prev_error >= DEG_90) && (err_wrapped <= -DEG_90)) begin
				err_limited <= DEG_90;
			end else if ((prev_error <= -DEG_90) && (err_wrapped >= DEG_90)) begin
				err_limited <= -DEG_90;
			end else if (err_wrapped < rate_floor) begin
				err_limited <= rate_floor;
			end else if (err_wrapped > rate_ceil) begin
				err_limited <= rate_ceil;
			end else begin
				err_limited <= err_wrapped;
			end
		end
	end

	// Output stage, bypass passes the raw stick through
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			body_yaw_angle_target <= '0;
			yaw_angle_error_out   <= '0;
		end else if (err_clamp_step) begin
			if (yaac_enable_n) begin
				body_yaw_angle_target <= stick_raw;
				yaw_angle_error_out   <= '0;
			end else begin
				body_yaw_angle_target <= target_angle;
				if (err_limited > DEG_90) begin
					yaw_angle_error_out <= DEG_90;
				end else if (err_limited < -DEG_90) begin
					yaw_angle_error_out <= -DEG_90;
				end else begin
					yaw_angle_error_out <= err_limited;
				end
			end
		end
	end

	// Reference for the next run's rate limit
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			prev_error <= '0;
		end else if (commit_step) begin
			prev_error <= err_limited;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/yaw_angle_accumulator.sv ====
`default_nettype none

module yaw_angle_accumulator (
	input  wire                         us_clk,
	input  wire                         resetn,
	input  wire                         start_signal,
	input  wire                         yaac_enable_n,
	input  wire yaw_angle_pkg::stick_t  throttle_pwm_value_input,
	input  wire yaw_angle_pkg::stick_t  yaw_pwm_value_input,
	input  wire yaw_angle_pkg::angle_t  yaw_angle_imu,
	output yaw_angle_pkg::angle_t       body_yaw_angle_target,
	output yaw_angle_pkg::angle_t       yaw_angle_error_out,
	output logic                        active_signal,
	output logic                        complete_signal,
	output logic                        yaw_stick_out_of_neutral_window
);
	import yaw_angle_pkg::*;

	// Step strobes from the sequencer
	logic latch_step;
	logic neutral_step;
	logic normalize_step;
	logic window_step;
	logic track_sum_step;
	logic track_wrap_step;
	logic target_step;
	logic err_diff_step;
	logic err_wrap_step;
	logic err_rate_step;
	logic err_clamp_step;
	logic commit_step;

	// Datapath between the stages
	angle_t imu_angle;
	angle_t stick_raw;
	angle_t stick_norm;
	angle_t target_angle;
	logic   throttle_idle;

	yaw_sequencer u_sequencer (
		.us_clk          (us_clk),
		.resetn          (resetn),
		.start_signal    (start_signal),
		.active_signal   (active_signal),
		.complete_signal (complete_signal),
		.latch_step      (latch_step),
		.neutral_step    (neutral_step),
		.normalize_step  (normalize_step),
		.window_step     (window_step),
		.track_sum_step  (track_sum_step),
		.track_wrap_step (track_wrap_step),
		.target_step     (target_step),
		.err_diff_step   (err_diff_step),
		.err_wrap_step   (err_wrap_step),
		.err_rate_step   (err_rate_step),
		.err_clamp_step  (err_clamp_step),
		.commit_step     (commit_step)
	);

	stick_conditioner u_stick (
		.us_clk                   (us_clk),
		.resetn                   (resetn),
		.latch_step               (latch_step),
		.neutral_step             (neutral_step),
		.normalize_step           (normalize_step),
		.window_step              (window_step),
		.throttle_pwm_value_input (throttle_pwm_value_input),
		.yaw_pwm_value_input      (yaw_pwm_value_input),
		.yaw_angle_imu            (yaw_angle_imu),
		.imu_angle                (imu_angle),
		.stick_raw                (stick_raw),
		.stick_norm               (stick_norm),
		.throttle_idle            (throttle_idle),
		.out_of_window            (yaw_stick_out_of_neutral_window)
	);

	heading_tracker u_tracker (
		.us_clk          (us_clk),
		.resetn          (resetn),
		.track_sum_step  (track_sum_step),
		.track_wrap_step (track_wrap_step),
		.target_step     (target_step),
		.throttle_idle   (throttle_idle),
		.out_of_window   (yaw_stick_out_of_neutral_window),
		.stick_norm      (stick_norm),
		.imu_angle       (imu_angle),
		.target_angle    (target_angle)
	);

	heading_error u_error (
		.us_clk                (us_clk),
		.resetn                (resetn),
		.err_diff_step         (err_diff_step),
		.err_wrap_step         (err_wrap_step),
		.err_rate_step         (err_rate_step),
		.err_clamp_step        (err_clamp_step),
		.commit_step           (commit_step),
		.yaac_enable_n         (yaac_enable_n),
		.throttle_idle         (throttle_idle),
		.target_angle          (target_angle),
		.imu_angle             (imu_angle),
		.stick_raw             (stick_raw),
		.body_yaw_angle_target (body_yaw_angle_target),
		.yaw_angle_error_out   (yaw_angle_error_out)
	);

endmodule

`default_nettype wire

// ==== tb/tb_yaw_angle_accumulator.sv ====
`default_nettype none

module tb_yaw_angle_accumulator;
	timeunit 1ns;
	timeprecision 1ps;

	import yaw_angle_pkg::*;

	localparam int CLK_PERIOD    = 8;
	localparam int RESET_CYCLES  = 10;
	// A run takes about 15 cycles from start to the end of complete
	localparam int RUN_BUDGET    = 20;
	localparam int RUN_LATENCY   = 12;
	localparam int ACTIVE_CYCLES = 11;

	logic   us_clk = 1'b0;
	logic   resetn;
	logic   start_signal;
	logic   yaac_enable_n;
	stick_t throttle_pwm_value_input;
	stick_t yaw_pwm_value_input;
	angle_t yaw_angle_imu;
	angle_t body_yaw_angle_target;
	angle_t yaw_angle_error_out;
	logic   active_signal;
	logic   complete_signal;
	logic   yaw_stick_out_of_neutral_window;

	// Trace columns with one entry per run
	int thr_q[$];
	int yaw_q[$];
	int imu_q[$];
	int en_q[$];
	int exp_target_q[$];
	int exp_error_q[$];
	int exp_window_q[$];

	int error_count = 0;
	int load_errors = 0;
	int pass_count  = 0;
	int fail_count  = 0;
	int timeout_ns  = 0;
	bit trace_loaded = 1'b0;

	yaw_angle_accumulator dut (
		.us_clk                          (us_clk),
		.resetn                          (resetn),
		.start_signal                    (start_signal),
		.yaac_enable_n                   (yaac_enable_n),
		.throttle_pwm_value_input        (throttle_pwm_value_input),
		.yaw_pwm_value_input             (yaw_pwm_value_input),
		.yaw_angle_imu                   (yaw_angle_imu),
		.body_yaw_angle_target           (body_yaw_angle_target),
		.yaw_angle_error_out             (yaw_angle_error_out),
		.active_signal                   (active_signal),
		.complete_signal                 (complete_signal),
		.yaw_stick_out_of_neutral_window (yaw_stick_out_of_neutral_window)
	);

	always #(CLK_PERIOD / 2) us_clk = ~us_clk;

	task automatic check_value(input string what, input logic signed [31:0] got,
			input logic signed [31:0] expected);
		if (got !== expected) begin
			$display("MISMATCH at %0d ns: %s got %0d expected %0d", $time, what, got, expected);
			error_count++;
		end
	endtask

	task automatic report_test(input int number, input int errors_before);
		if (error_count == errors_before) begin
			$display("test %0d: passed", number);
			pass_count++;
		end else begin
			$display("test %0d: failed", number);
			fail_count++;
		end
	endtask

	task automatic load_trace();
		int    fd;
		string line;
		int    fields;
		int    thr;
		int    yaw;
		int    imu;
		int    en_n;
		int    e_target;
		int    e_error;
		int    e_window;
		fd = $fopen("tb/yaw_trace.dat", "r");
		if (fd == 0) begin
			$display("Could not open the trace file tb/yaw_trace.dat");
			load_errors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				// Lines starting with # are comments
				if (line.len() > 0 && line.getc(0) != "#") begin
					fields = $sscanf(line, "%d %d %d %d %d %d %d", thr, yaw, imu, en_n,
						e_target, e_error, e_window);
					if (fields == 7) begin
						thr_q.push_back(thr);
						yaw_q.push_back(yaw);
						imu_q.push_back(imu);
						en_q.push_back(en_n);
						exp_target_q.push_back(e_target);
						exp_error_q.push_back(e_error);
						exp_window_q.push_back(e_window);
					end else if (fields > 0) begin
						$display("Trace line has the wrong number of columns: %s", line);
						load_errors++;
					end
				end
			end
			$fclose(fd);
		end
		if (thr_q.size() == 0) begin
			$display("The trace file holds no runs");
			load_errors++;
		end
	endtask

	// Drive one trace line, wait for complete and compare the outputs
	task automatic run_trace_line(input int idx);
		int cycles;
		int active_cycles;
		bit done;
		int errors_before;
		errors_before = error_count;
		throttle_pwm_value_input = stick_t'(thr_q[idx]);
		yaw_pwm_value_input      = stick_t'(yaw_q[idx]);
		yaw_angle_imu            = angle_t'(imu_q[idx]);
		yaac_enable_n            = (en_q[idx] != 0);
		start_signal             = 1'b1;
		@(negedge us_clk);
		start_signal = 1'b0;
		cycles = 0;
		active_cycles = 0;
		done = 1'b0;
		while (!done && cycles < RUN_BUDGET) begin
			@(negedge us_clk);
			cycles++;
			if (active_signal) begin
				active_cycles++;
			end
			if (complete_signal) begin
				done = 1'b1;
			end
		end
		if (!done) begin
			$display("Run %0d: complete_signal did not rise within %0d cycles", idx + 1,
				RUN_BUDGET);
			error_count++;
		end else begin
			// First counted edge is the one that leaves IDLE
			check_value("cycles to complete", cycles - 1, RUN_LATENCY);
			check_value("active cycles", active_cycles, ACTIVE_CYCLES);
			check_value("body yaw target", 32'(body_yaw_angle_target), exp_target_q[idx]);
			check_value("yaw error", 32'(yaw_angle_error_out), exp_error_q[idx]);
			check_value("window flag", 32'(yaw_stick_out_of_neutral_window),
				exp_window_q[idx]);
			@(negedge us_clk);
			check_value("complete after one cycle", 32'(complete_signal), 0);
		end
		report_test(idx + 1, errors_before);
	endtask

	initial begin
		wait (trace_loaded);
		#(timeout_ns);
		$display("Timeout: the runs did not finish within %0d ns", timeout_ns);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		int errors_before;
		int i;
		resetn                   = 1'b0;
		start_signal             = 1'b0;
		yaac_enable_n            = 1'b0;
		throttle_pwm_value_input = '0;
		yaw_pwm_value_input      = '0;
		yaw_angle_imu            = '0;

		load_trace();
		timeout_ns = (thr_q.size() * RUN_BUDGET + RESET_CYCLES + 2) * CLK_PERIOD;
		trace_loaded = 1'b1;

		repeat (RESET_CYCLES) @(posedge us_clk);
		@(negedge us_clk);
		resetn = 1'b1;

		// Test 0 covers the state right after reset
		errors_before = error_count;
		check_value("target after reset", 32'(body_yaw_angle_target), 0);
		check_value("error after reset", 32'(yaw_angle_error_out), 0);
		check_value("active after reset", 32'(active_signal), 0);
		check_value("complete after reset", 32'(complete_signal), 0);
		check_value("window after reset", 32'(yaw_stick_out_of_neutral_window), 0);
		report_test(0, errors_before);

		for (i = 0; i < thr_q.size(); i++) begin
			run_trace_line(i);
		end

		$display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (fail_count == 0 && load_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/yaw_trace.dat ====
# throttle yaw imu enable_n | expected: target error window
# decimal, angles in IMU counts (16 per degree)
0 128 1600 0 1600 0 0
0 120 800 0 800 0 0
100 122 800 0 800 0 0
100 117 820 0 800 -20 0
100 124 800 0 801 1 1
100 200 821 0 821 0 1
100 116 821 0 820 -1 1
0 120 5750 0 5750 0 0
100 220 5750 0 15 25 1
100 20 10 0 5750 -20 1
0 120 5600 0 5600 0 0
# seam: target 350 deg, IMU 10 deg
100 121 160 0 5600 -50 0
100 121 160 0 5600 -100 0
# error of +2000 builds up 50 per run, then clamps
100 121 3600 0 5600 -50 0
100 121 3600 0 5600 0 0
100 121 3600 0 5600 50 0
100 121 3600 0 5600 100 0
100 121 3600 0 5600 150 0
100 121 3600 0 5600 200 0
100 121 3600 0 5600 250 0
100 121 3600 0 5600 300 0
100 121 3600 0 5600 350 0
100 121 3600 0 5600 400 0
100 121 3600 0 5600 450 0
100 121 3600 0 5600 500 0
100 121 3600 0 5600 550 0
100 121 3600 0 5600 600 0
100 121 3600 0 5600 650 0
100 121 3600 0 5600 700 0
100 121 3600 0 5600 750 0
100 121 3600 0 5600 800 0
100 121 3600 0 5600 850 0
100 121 3600 0 5600 900 0
100 121 3600 0 5600 950 0
100 121 3600 0 5600 1000 0
100 121 3600 0 5600 1050 0
100 121 3600 0 5600 1100 0
100 121 3600 0 5600 1150 0
100 121 3600 0 5600 1200 0
100 121 3600 0 5600 1250 0
100 121 3600 0 5600 1300 0
100 121 3600 0 5600 1350 0
100 121 3600 0 5600 1400 0
100 121 3600 0 5600 1440 0
100 121 3600 0 5600 1440 0
# jump to -97.5 deg holds at +90 deg
100 121 1400 0 5600 1440 0
100 121 1400 0 5600 1440 0
# bypass
100 150 5607 1 150 0 1
0 90 300 1 90 0 0

// ==== all.f ====
+incdir+verilog
verilog/yaw_angle_pkg.sv
verilog/yaw_seq_pkg.sv
verilog/yaw_sequencer.sv
verilog/stick_conditioner.sv
verilog/heading_tracker.sv
verilog/heading_error.sv
verilog/yaw_angle_accumulator.sv
tb/tb_yaw_angle_accumulator.sv

// ==== Makefile ====
VERILATOR  = verilator
FILELIST   = all.f
TB_TOP     = tb_yaw_angle_accumulator
RTL_TOP    = yaw_angle_accumulator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing -j 0
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = Simulation finished: FAIL

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
